// File: dv/shot_mover_stim.txt
# F dir x y dropped | M live_count | R slot live dir x y
# dir codes 0 right 1 left 2 down 3 up
F 0 10 5 0
F 1 20 6 0
F 2 7 12 0
F 3 30 15 0
R 0 1 0 10 5
R 3 1 3 30 15
M 4
R 0 1 0 11 5
R 1 1 1 19 6
R 2 1 2 7 13
R 3 1 3 30 14
R 4 0 0 0 0
F 0 39 3 0
F 1 0 8 0
F 2 4 29 0
F 3 9 0 0
F 0 1 1 1
M 4
R 4 0 0 0 0
R 7 0 0 0 0
R 0 1 0 12 5
F 2 3 3 0
R 4 1 2 3 3
M 5
R 4 1 2 3 4
R 1 1 1 17 6
R 6 0 0 0 0

// File: dv/shot_mover_tb.sv
`timescale 1ns/1ps
`default_nettype none

module shot_mover_tb import shot_pkg::*; ();

    localparam int NUM_SHOTS       = DEFAULT_NUM_SHOTS;
    localparam int COORD_WIDTH     = DEFAULT_COORD_WIDTH;
    localparam int INDEX_WIDTH     = (NUM_SHOTS > 1) ? $clog2(NUM_SHOTS) : 1;
    localparam int COUNT_WIDTH     = $clog2(NUM_SHOTS + 1);
    localparam int CYCLES_PER_LINE = 200;
    localparam string STIM_PATH    = "dv/shot_mover_stim.txt";

    logic                   clock;
    logic                   reset;
    logic                   fire;
    shot_dir_t              fire_dir;
    logic [COORD_WIDTH-1:0] fire_x;
    logic [COORD_WIDTH-1:0] fire_y;
    logic                   move;
    logic [INDEX_WIDTH-1:0] read_index;
    logic                   fire_dropped;
    logic                   sweep_active;
    logic                   done;
    logic [COUNT_WIDTH-1:0] live_count;
    logic                   read_live;
    shot_dir_t              read_dir;
    logic [COORD_WIDTH-1:0] read_x;
    logic [COORD_WIDTH-1:0] read_y;

    string stim_lines [$]; // Command lines only
    bit    stim_loaded;
    bit    model_live [NUM_SHOTS];
    int    model_dir [NUM_SHOTS];
    int    model_x [NUM_SHOTS];
    int    model_y [NUM_SHOTS];
    int    model_count; // Survivors of the last finished sweep

    shot_mover_top shot_mover_top_inst (
        .clock        (clock),
        .reset        (reset),
        .fire         (fire),
        .fire_dir     (fire_dir),
        .fire_x       (fire_x),
        .fire_y       (fire_y),
        .move         (move),
        .read_index   (read_index),
        .fire_dropped (fire_dropped),
        .sweep_active (sweep_active),
        .done         (done),
        .live_count   (live_count),
        .read_live    (read_live),
        .read_dir     (read_dir),
        .read_x       (read_x),
        .read_y       (read_y)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_error(input string what);
        abort_run($sformatf("[ERROR] t=%0d ns: %s", $time, what));
    endtask

    task automatic next_cycle;
        @(posedge clock);
        #1; // Drive and sample away from the edge
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_error($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic check_count(input logic [COUNT_WIDTH-1:0] expected);
        if (live_count !== expected)
            report_error($sformatf("live_count is %0d, expected %0d", live_count, expected));
    endtask

    task automatic check_shot(input logic live, input shot_dir_t dir,
                              input logic [COORD_WIDTH-1:0] x, input logic [COORD_WIDTH-1:0] y);
        check_flag(read_live, live, $sformatf("read_live of slot %0d", read_index));
        if (live && (read_dir !== dir || read_x !== x || read_y !== y)) // Dead data is stale
            report_error($sformatf("slot %0d holds dir %0d (%0d,%0d), expected dir %0d (%0d,%0d)",
                read_index, read_dir, read_x, read_y, dir, x, y));
    endtask

    task automatic load_stim;
        int    fd;
        int    status;
        string line;
        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            abort_run($sformatf("Could not open the stimulus file %s", STIM_PATH));
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (status > 0 && line.getc(0) != "#" && line.getc(0) != 8'h0a)
                    stim_lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // Lowest free slot takes the shot
    task automatic model_fire(input int dir, input int x, input int y, output bit dropped);
        logic [INDEX_WIDTH-1:0] slot;
        dropped = 1'b1;
        for (int i = 0; i < NUM_SHOTS; i++) begin
            slot = INDEX_WIDTH'(i);
            if (dropped && !model_live[slot]) begin
                dropped          = 1'b0;
                model_live[slot] = 1'b1;
                model_dir[slot]  = dir;
                model_x[slot]    = x;
                model_y[slot]    = y;
            end
        end
    endtask

    task automatic model_move(output int survivors);
        logic [INDEX_WIDTH-1:0] slot;
        bit                     at_edge;
        int                     dx;
        int                     dy;
        survivors = 0;
        for (int i = 0; i < NUM_SHOTS; i++) begin
            slot = INDEX_WIDTH'(i);
            if (model_live[slot]) begin
                dx = 0;
                dy = 0;
                case (model_dir[slot])
                    0: begin
                        at_edge = (model_x[slot] == DEFAULT_X_MAX);
                        dx      = 1;
                    end
                    1: begin
                        at_edge = (model_x[slot] == 0);
                        dx      = -1;
                    end
                    2: begin
                        at_edge = (model_y[slot] == DEFAULT_Y_MAX);
                        dy      = 1;
                    end
                    default: begin
                        at_edge = (model_y[slot] == 0);
                        dy      = -1;
                    end
                endcase
                if (at_edge) begin
                    model_live[slot] = 1'b0; // Off screen
                end else begin
                    model_x[slot] = model_x[slot] + dx;
                    model_y[slot] = model_y[slot] + dy;
                    survivors++;
                end
            end
        end
    endtask

    task automatic run_fire(input string line, input int line_no);
        int a, b, c, d;
        bit dropped;
        if ($sscanf(line, "F %d %d %d %d", a, b, c, d) != 4)
            abort_run($sformatf("Stimulus line %0d is not a valid fire command", line_no));
        model_fire(a, b, c, dropped);
        if (dropped != d[0])
            abort_run($sformatf("Stimulus line %0d disagrees with the reference model", line_no));
        fire     = 1'b1;
        fire_dir = shot_dir_t'(2'(a));
        fire_x   = COORD_WIDTH'(b);
        fire_y   = COORD_WIDTH'(c);
        next_cycle();
        fire = 1'b0;
        check_flag(fire_dropped, d[0], "fire_dropped");
    endtask

    task automatic run_move(input string line, input int line_no);
        int a;
        int survivors;
        if ($sscanf(line, "M %d", a) != 1)
            abort_run($sformatf("Stimulus line %0d is not a valid move command", line_no));
        model_move(survivors);
        if (survivors != a)
            abort_run($sformatf("Stimulus line %0d disagrees with the reference model", line_no));
        move = 1'b1;
        next_cycle();
        move = 1'b0;
        check_flag(sweep_active, 1'b1, "sweep_active after move");
        fire     = 1'b1; // Both strobes must be ignored mid sweep
        move     = 1'b1;
        fire_dir = dir_right;
        fire_x   = COORD_WIDTH'(2);
        fire_y   = COORD_WIDTH'(2);
        next_cycle();
        fire = 1'b0;
        move = 1'b0;
        check_flag(fire_dropped, 1'b0, "fire_dropped during sweep");
        while (!done) begin
            check_count(COUNT_WIDTH'(model_count)); // Last result holds during the sweep
            next_cycle(); // Watchdog bounds this wait
        end
        check_count(COUNT_WIDTH'(a));
        next_cycle();
        check_flag(done, 1'b0, "done one cycle after done");
        check_flag(sweep_active, 1'b0, "sweep_active after done");
        check_count(COUNT_WIDTH'(a));
        model_count = a;
    endtask

    task automatic run_read(input string line, input int line_no);
        int a, b, c, d, e;
        logic [INDEX_WIDTH-1:0] slot;
        if ($sscanf(line, "R %d %d %d %d %d", a, b, c, d, e) != 5)
            abort_run($sformatf("Stimulus line %0d is not a valid read command", line_no));
        slot = INDEX_WIDTH'(a);
        if (model_live[slot] != b[0] ||
            (b != 0 && (model_dir[slot] != c || model_x[slot] != d || model_y[slot] != e)))
            abort_run($sformatf("Stimulus line %0d disagrees with the reference model", line_no));
        read_index = slot;
        next_cycle();
        check_shot(b[0], shot_dir_t'(2'(c)), COORD_WIDTH'(d), COORD_WIDTH'(e));
    endtask

    task automatic check_reset_state;
        check_flag(done, 1'b0, "done after reset");
        check_flag(sweep_active, 1'b0, "sweep_active after reset");
        check_flag(fire_dropped, 1'b0, "fire_dropped after reset");
        check_count('0);
        for (int i = 0; i < NUM_SHOTS; i++) begin
            read_index = INDEX_WIDTH'(i);
            next_cycle();
            check_flag(read_live, 1'b0, $sformatf("read_live of slot %0d after reset", i));
        end
    endtask

    initial begin
        int limit_cycles;
        wait (stim_loaded);
        limit_cycles = (stim_lines.size() + 1) * CYCLES_PER_LINE;
        repeat (limit_cycles) @(posedge clock);
        abort_run($sformatf("Watchdog expired after %0d cycles before the run ended",
            limit_cycles));
    end

    initial begin
        byte cmd;
        reset       = 1'b1;
        fire        = 1'b0;
        fire_dir    = dir_right;
        fire_x      = '0;
        fire_y      = '0;
        move        = 1'b0;
        read_index  = '0;
        model_count = 0;
        load_stim();
        stim_loaded = 1'b1;
        repeat (16) @(posedge clock);
        #1 reset = 1'b0;
        check_reset_state();
        foreach (stim_lines[n]) begin
            cmd = stim_lines[n].getc(0);
            if (cmd == "F")
                run_fire(stim_lines[n], n + 1);
            else if (cmd == "M")
                run_move(stim_lines[n], n + 1);
            else if (cmd == "R")
                run_read(stim_lines[n], n + 1);
            else
                abort_run($sformatf("Unknown command on stimulus line %0d", n + 1));
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/shot_pkg.sv
logic/shot_stepper.sv
logic/shot_census.sv
logic/shot_memory.sv
logic/move_control.sv
logic/shot_mover_top.sv
dv/shot_mover_tb.sv

// File: logic/move_control.sv
`timescale 1ns/1ps
`default_nettype none

module move_control import shot_pkg::*; #(
    parameter int NUM_SHOTS = DEFAULT_NUM_SHOTS,
    localparam int INDEX_WIDTH = (NUM_SHOTS > 1) ? $clog2(NUM_SHOTS) : 1
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    move,
    input  wire                    cur_live,
    input  wire                    at_border,
    output logic [INDEX_WIDTH-1:0] sweep_index,
    output logic                   sweep_active,
    output logic                   write_pos,
    output logic                   write_kill,
    output logic                   count_clear,
    output logic                   count_live,
    output logic                   done
);

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(NUM_SHOTS - 1);

    move_state_t state;
    move_state_t next_state;
    logic        last_slot;

    assign last_slot = (sweep_index == LAST_INDEX);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Index follows the state, one slot per pass through st_advance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sweep_index <= '0;
        end else if (state == st_clear_index) begin
            sweep_index <= '0;
        end else if (state == st_advance && !last_slot) begin
            sweep_index <= sweep_index + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (move)
                    next_state = st_clear_index; // Later moves ignored until idle
            end
            st_clear_index: begin
                next_state = st_check_live;
            end
            st_check_live: begin
                next_state = cur_live ? st_check_border : st_settle;
            end
            st_check_border: begin
                next_state = at_border ? st_retire : st_pick_dir;
            end
            st_retire: begin
                next_state = st_advance;
            end
            st_pick_dir: begin
                next_state = st_step; // Stepper output settles on cur_dir here
            end
            st_step: begin
                next_state = st_advance;
            end
            st_settle: begin
                next_state = st_advance; // Dead slot
            end
            st_advance: begin
                next_state = last_slot ? st_done : st_check_live;
            end
            st_done: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Moore outputs
    always_comb begin
        sweep_active = (state != st_idle);
        count_clear  = (state == st_clear_index);
        write_kill   = (state == st_retire);
        write_pos    = (state == st_step);
        count_live   = (state == st_step); // Only stepped shots survive
        done         = (state == st_done);
    end

    done_pulse_a: assert property (@(posedge clock) disable iff (reset)
        done |=> !done);

    index_range_a: assert property (@(posedge clock) disable iff (reset)
        sweep_index <= LAST_INDEX);

endmodule

`default_nettype wire

// File: logic/shot_census.sv
`timescale 1ns/1ps
`default_nettype none

module shot_census import shot_pkg::*; #(
    parameter int NUM_SHOTS = DEFAULT_NUM_SHOTS,
    localparam int COUNT_WIDTH = $clog2(NUM_SHOTS + 1)
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    count_clear,
    input  wire                    count_live,
    input  wire                    done,
    output logic [COUNT_WIDTH-1:0] live_count
);

    logic [COUNT_WIDTH-1:0] running_count; // Survivors so far in this sweep
    logic [COUNT_WIDTH-1:0] held_count;    // Result of the last finished sweep

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running_count <= '0;
            held_count    <= '0;
        end else begin
            if (count_clear)
                running_count <= '0;
            else if (count_live)
                running_count <= running_count + 1'b1;
            if (done)
                held_count <= running_count;
        end
    end

    // New total shows while done is high, then the held copy takes over
    assign live_count = done ? running_count : held_count;

endmodule

`default_nettype wire

// File: logic/shot_memory.sv
`timescale 1ns/1ps
`default_nettype none

module shot_memory import shot_pkg::*; #(
    parameter int NUM_SHOTS   = DEFAULT_NUM_SHOTS,
    parameter int COORD_WIDTH = DEFAULT_COORD_WIDTH,
    localparam int INDEX_WIDTH = (NUM_SHOTS > 1) ? $clog2(NUM_SHOTS) : 1
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     fire,
    input  wire shot_dir_t          fire_dir,
    input  wire [COORD_WIDTH-1:0]   fire_x,
    input  wire [COORD_WIDTH-1:0]   fire_y,
    input  wire                     sweep_active,
    input  wire [INDEX_WIDTH-1:0]   sweep_index,
    input  wire                     write_pos,
    input  wire                     write_kill,
    input  wire [COORD_WIDTH-1:0]   next_x,
    input  wire [COORD_WIDTH-1:0]   next_y,
    input  wire [INDEX_WIDTH-1:0]   read_index,
    output logic                    fire_dropped,
    output logic                    cur_live,
    output shot_dir_t               cur_dir,
    output logic [COORD_WIDTH-1:0]  cur_x,
    output logic [COORD_WIDTH-1:0]  cur_y,
    output logic                    read_live,
    output shot_dir_t               read_dir,
    output logic [COORD_WIDTH-1:0]  read_x,
    output logic [COORD_WIDTH-1:0]  read_y
);

    logic [NUM_SHOTS-1:0]   shot_live;
    shot_dir_t              shot_dir [NUM_SHOTS];
    logic [COORD_WIDTH-1:0] shot_x [NUM_SHOTS];
    logic [COORD_WIDTH-1:0] shot_y [NUM_SHOTS];
    logic                   free_found;
    logic [INDEX_WIDTH-1:0] free_slot;
    logic                   fire_accept;

    // Walk down from the top so the lowest free slot wins
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = NUM_SHOTS - 1; i >= 0; i--) begin
            if (!shot_live[i]) begin
                free_found = 1'b1;
                free_slot  = INDEX_WIDTH'(i);
            end
        end
    end

    assign fire_accept = fire && !sweep_active && free_found; // Table frozen during a sweep

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            shot_live    <= '0;
            fire_dropped <= 1'b0;
        end else begin
            fire_dropped <= fire && !sweep_active && !free_found; // Full table
            if (fire_accept)
                shot_live[free_slot] <= 1'b1;
            if (write_kill)
                shot_live[sweep_index] <= 1'b0; // Shot left the screen
        end
    end

    always_ff @(posedge clock) begin
        if (fire_accept) begin
            shot_dir[free_slot] <= fire_dir;
            shot_x[free_slot]   <= fire_x;
            shot_y[free_slot]   <= fire_y;
        end
        if (write_pos) begin
            shot_x[sweep_index] <= next_x; // Stepper keeps the idle axis unchanged
            shot_y[sweep_index] <= next_y;
        end
    end

    assign cur_live  = shot_live[sweep_index];
    assign cur_dir   = shot_dir[sweep_index];
    assign cur_x     = shot_x[sweep_index];
    assign cur_y     = shot_y[sweep_index];
    assign read_live = shot_live[read_index];
    assign read_dir  = shot_dir[read_index];
    assign read_x    = shot_x[read_index];
    assign read_y    = shot_y[read_index];

    // A slot is either stepped or retired in one visit, never both
    write_exclusive_a: assert property (@(posedge clock) disable iff (reset)
        !(write_pos && write_kill));

endmodule

`default_nettype wire

// File: logic/shot_mover_top.sv
`timescale 1ns/1ps
`default_nettype none

module shot_mover_top import shot_pkg::*; #(
    parameter int NUM_SHOTS   = DEFAULT_NUM_SHOTS,
    parameter int COORD_WIDTH = DEFAULT_COORD_WIDTH,
    parameter int X_MAX       = DEFAULT_X_MAX,
    parameter int Y_MAX       = DEFAULT_Y_MAX,
    localparam int INDEX_WIDTH = (NUM_SHOTS > 1) ? $clog2(NUM_SHOTS) : 1,
    localparam int COUNT_WIDTH = $clog2(NUM_SHOTS + 1)
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     fire,
    input  wire shot_dir_t          fire_dir,
    input  wire [COORD_WIDTH-1:0]   fire_x,
    input  wire [COORD_WIDTH-1:0]   fire_y,
    input  wire                     move,
    input  wire [INDEX_WIDTH-1:0]   read_index,
    output logic                    fire_dropped,
    output logic                    sweep_active,
    output logic                    done,
    output logic [COUNT_WIDTH-1:0]  live_count,
    output logic                    read_live,
    output shot_dir_t               read_dir,
    output logic [COORD_WIDTH-1:0]  read_x,
    output logic [COORD_WIDTH-1:0]  read_y
);

    logic [INDEX_WIDTH-1:0] sweep_index;
    logic                   write_pos;
    logic                   write_kill;
    logic                   count_clear;
    logic                   count_live;
    logic                   cur_live;
    shot_dir_t              cur_dir;
    logic [COORD_WIDTH-1:0] cur_x;
    logic [COORD_WIDTH-1:0] cur_y;
    logic                   at_border;
    logic [COORD_WIDTH-1:0] next_x;
    logic [COORD_WIDTH-1:0] next_y;

    // Input side, the shot table
    shot_memory #(
        .NUM_SHOTS   (NUM_SHOTS),
        .COORD_WIDTH (COORD_WIDTH)
    ) shot_memory_inst (
        .clock        (clock),
        .reset        (reset),
        .fire         (fire),
        .fire_dir     (fire_dir),
        .fire_x       (fire_x),
        .fire_y       (fire_y),
        .sweep_active (sweep_active),
        .sweep_index  (sweep_index),
        .write_pos    (write_pos),
        .write_kill   (write_kill),
        .next_x       (next_x),
        .next_y       (next_y),
        .read_index   (read_index),
        .fire_dropped (fire_dropped),
        .cur_live     (cur_live),
        .cur_dir      (cur_dir),
        .cur_x        (cur_x),
        .cur_y        (cur_y),
        .read_live    (read_live),
        .read_dir     (read_dir),
        .read_x       (read_x),
        .read_y       (read_y)
    );

    move_control #(
        .NUM_SHOTS (NUM_SHOTS)
    ) move_control_inst (
        .clock        (clock),
        .reset        (reset),
        .move         (move),
        .cur_live     (cur_live),
        .at_border    (at_border),
        .sweep_index  (sweep_index),
        .sweep_active (sweep_active),
        .write_pos    (write_pos),
        .write_kill   (write_kill),
        .count_clear  (count_clear),
        .count_live   (count_live),
        .done         (done)
    );

    shot_stepper #(
        .COORD_WIDTH (COORD_WIDTH),
        .X_MAX       (X_MAX),
        .Y_MAX       (Y_MAX)
    ) shot_stepper_inst (
        .cur_dir   (cur_dir),
        .cur_x     (cur_x),
        .cur_y     (cur_y),
        .at_border (at_border),
        .next_x    (next_x),
        .next_y    (next_y)
    );

    // Output side, survivor count
    shot_census #(
        .NUM_SHOTS (NUM_SHOTS)
    ) shot_census_inst (
        .clock       (clock),
        .reset       (reset),
        .count_clear (count_clear),
        .count_live  (count_live),
        .done        (done),
        .live_count  (live_count)
    );

endmodule

`default_nettype wire

// File: logic/shot_pkg.sv
`default_nettype none

package shot_pkg;

    // Direction of travel, X grows to the right and Y grows downward
    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_down  = 2'd2,
        dir_up    = 2'd3
    } shot_dir_t;

    typedef enum logic [3:0] {
        st_idle,
        st_clear_index,
        st_check_live,
        st_check_border,
        st_retire,
        st_pick_dir,
        st_step,
        st_advance,
        st_settle,
        st_done
    } move_state_t;

    localparam int DEFAULT_NUM_SHOTS   = 8;
    localparam int DEFAULT_COORD_WIDTH = 6;
    localparam int DEFAULT_X_MAX       = 39; // Right screen edge
    localparam int DEFAULT_Y_MAX       = 29; // Bottom screen edge

endpackage

`default_nettype wire

// File: logic/shot_stepper.sv
`timescale 1ns/1ps
`default_nettype none

module shot_stepper import shot_pkg::*; #(
    parameter int COORD_WIDTH = DEFAULT_COORD_WIDTH,
    parameter int X_MAX       = DEFAULT_X_MAX,
    parameter int Y_MAX       = DEFAULT_Y_MAX
) (
    input  wire shot_dir_t          cur_dir,
    input  wire [COORD_WIDTH-1:0]   cur_x,
    input  wire [COORD_WIDTH-1:0]   cur_y,
    output logic                    at_border,
    output logic [COORD_WIDTH-1:0]  next_x,
    output logic [COORD_WIDTH-1:0]  next_y
);

    localparam logic [COORD_WIDTH-1:0] X_LIMIT = COORD_WIDTH'(X_MAX);
    localparam logic [COORD_WIDTH-1:0] Y_LIMIT = COORD_WIDTH'(Y_MAX);

    // One decode drives both the edge test and the step
    always_comb begin
        at_border = 1'b0;
        next_x    = cur_x;
        next_y    = cur_y;
        case (cur_dir)
            dir_right: begin
                at_border = (cur_x == X_LIMIT);
                next_x    = cur_x + 1'b1;
            end
            dir_left: begin
                at_border = (cur_x == '0);
                next_x    = cur_x - 1'b1;
            end
            dir_down: begin
                at_border = (cur_y == Y_LIMIT);
                next_y    = cur_y + 1'b1;
            end
            dir_up: begin
                at_border = (cur_y == '0); // Top edge
                next_y    = cur_y - 1'b1;
            end
            default: begin
                at_border = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the shot mover testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module shot_mover_tb -f flist.f \
    && ./obj_dir/Vshot_mover_tb \
    || { echo "Build or run returned an error status"; exit 1; }
